// ==== design/soc_bus_pkg.sv ====
package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite, split by the side that drives it
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axil_req_t;

  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
  } axil_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  // expands a byte strobe into a bit mask over the data word
  function automatic data_t strb_mask(strb_t strb);
    data_t mask;
    for (int i = 0; i < 4; i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

  // offset of a register inside its 4 KB region
  typedef logic [11:0] reg_off_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // region decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [31:0] NATV_BASE   = 32'h1000_0000;
  localparam logic [31:0] APB_BASE    = 32'h2000_0000;
  // the bits above the mask pick the region, the rest is the register offset
  localparam logic [31:0] REGION_MASK = 32'hFFFF_F000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam reg_off_t GPIO_OUT  = 12'h000;
  localparam reg_off_t GPIO_OEN  = 12'h004;
  // read only, reflects the synchronized pins
  localparam reg_off_t GPIO_IN   = 12'h008;
  localparam reg_off_t GPIO_IE   = 12'h00C;
  // write one to clear
  localparam reg_off_t GPIO_PEND = 12'h010;

  localparam reg_off_t TMR_LOAD  = 12'h000;
  // bit 0 enables the count
  localparam reg_off_t TMR_CTRL  = 12'h004;
  localparam reg_off_t TMR_COUNT = 12'h008;
  // bit 0 is the sticky flag, write one to clear
  localparam reg_off_t TMR_STAT  = 12'h00C;

  // interrupt vector layout
  localparam int IRQ_NUM  = 2;
  localparam int IRQ_GPIO = 0;
  localparam int IRQ_TMR  = 1;

endpackage

// ==== design/axil_xbar.sv ====
module axil_xbar (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::axil_req_t mgr_req_i,
  output soc_bus_pkg::axil_rsp_t mgr_rsp_o,
  output soc_bus_pkg::axil_req_t natv_req_o,
  input  soc_bus_pkg::axil_rsp_t natv_rsp_i,
  output soc_bus_pkg::axil_req_t apb_req_o,
  input  soc_bus_pkg::axil_rsp_t apb_rsp_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic [1:0] {
    XB_IDLE,
    XB_FWD,
    XB_RESP
  } xb_state_e;

  xb_state_e state_q;
  logic      aw_got_q;
  logic      w_got_q;
  logic      a_sent_q;
  logic      w_sent_q;
  logic      is_wr_q;
  logic      sel_apb_q;
  addr_t     aw_addr_q;
  addr_t     addr_q;
  data_t     wdata_q;
  strb_t     wstrb_q;
  data_t     rdata_q;
  resp_t     resp_q;

  logic      aw_hs;
  logic      w_hs;
  logic      wr_go;
  logic      rd_go;
  addr_t     go_addr;
  logic      hit_natv;
  logic      hit_apb;
  logic      mgr_done;
  axil_req_t dn_req;
  axil_rsp_t dn_rsp;
  logic      dn_a_hs;
  logic      dn_w_hs;
  logic      dn_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // manager side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a read only wins while no beat of a write has been taken yet
  assign mgr_rsp_o.ar_ready = (state_q == XB_IDLE) && mgr_req_i.ar_valid
                              && !aw_got_q && !w_got_q;
  assign mgr_rsp_o.aw_ready = (state_q == XB_IDLE) && mgr_req_i.aw_valid && !aw_got_q
                              && (w_got_q || !mgr_req_i.ar_valid);
  assign mgr_rsp_o.w_ready  = (state_q == XB_IDLE) && mgr_req_i.w_valid && !w_got_q
                              && (aw_got_q || !mgr_req_i.ar_valid);
  assign mgr_rsp_o.b_valid  = (state_q == XB_RESP) && is_wr_q;
  assign mgr_rsp_o.b_resp   = resp_q;
  assign mgr_rsp_o.r_valid  = (state_q == XB_RESP) && !is_wr_q;
  assign mgr_rsp_o.r_data   = rdata_q;
  assign mgr_rsp_o.r_resp   = resp_q;

  assign aw_hs    = mgr_req_i.aw_valid && mgr_rsp_o.aw_ready;
  assign w_hs     = mgr_req_i.w_valid && mgr_rsp_o.w_ready;
  assign rd_go    = mgr_req_i.ar_valid && mgr_rsp_o.ar_ready;
  assign wr_go    = (aw_got_q || aw_hs) && (w_got_q || w_hs);
  assign mgr_done = (mgr_rsp_o.b_valid && mgr_req_i.b_ready)
                    || (mgr_rsp_o.r_valid && mgr_req_i.r_ready);

  assign go_addr  = rd_go ? mgr_req_i.ar_addr : (aw_got_q ? aw_addr_q : mgr_req_i.aw_addr);
  assign hit_natv = (go_addr & REGION_MASK) == NATV_BASE;
  assign hit_apb  = (go_addr & REGION_MASK) == APB_BASE;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // downstream replay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    dn_req = '0;
    if (state_q == XB_FWD) begin
      dn_req.aw_valid = is_wr_q && !a_sent_q;
      dn_req.aw_addr  = addr_q;
      dn_req.w_valid  = is_wr_q && !w_sent_q;
      dn_req.w_data   = wdata_q;
      dn_req.w_strb   = wstrb_q;
      dn_req.b_ready  = is_wr_q;
      dn_req.ar_valid = !is_wr_q && !a_sent_q;
      dn_req.ar_addr  = addr_q;
      dn_req.r_ready  = !is_wr_q;
    end
  end

  assign natv_req_o = sel_apb_q ? '0 : dn_req;
  assign apb_req_o  = sel_apb_q ? dn_req : '0;
  assign dn_rsp     = sel_apb_q ? apb_rsp_i : natv_rsp_i;

  assign dn_a_hs = (dn_req.aw_valid && dn_rsp.aw_ready) || (dn_req.ar_valid && dn_rsp.ar_ready);
  assign dn_w_hs = dn_req.w_valid && dn_rsp.w_ready;
  assign dn_done = (dn_req.b_ready && dn_rsp.b_valid) || (dn_req.r_ready && dn_rsp.r_valid);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= XB_IDLE;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      a_sent_q  <= 1'b0;
      w_sent_q  <= 1'b0;
      is_wr_q   <= 1'b0;
      sel_apb_q <= 1'b0;
    end else begin
      unique case (state_q)
        XB_IDLE: begin
          if (rd_go || wr_go) begin
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            a_sent_q  <= 1'b0;
            w_sent_q  <= 1'b0;
            is_wr_q   <= wr_go;
            sel_apb_q <= hit_apb;
            // unmapped addresses skip the peripherals entirely
            state_q   <= (hit_natv || hit_apb) ? XB_FWD : XB_RESP;
          end else begin
            if (aw_hs) aw_got_q <= 1'b1;
            if (w_hs) w_got_q <= 1'b1;
          end
        end
        XB_FWD: begin
          if (dn_a_hs) a_sent_q <= 1'b1;
          if (dn_w_hs) w_sent_q <= 1'b1;
          if (dn_done) state_q <= XB_RESP;
        end
        XB_RESP: begin
          if (mgr_done) state_q <= XB_IDLE;
        end
        default: state_q <= XB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) aw_addr_q <= mgr_req_i.aw_addr;
    if (w_hs) begin
      wdata_q <= mgr_req_i.w_data;
      wstrb_q <= mgr_req_i.w_strb;
    end
    if (rd_go || wr_go) begin
      addr_q  <= go_addr & ~REGION_MASK;
      // stands as the answer unless a subordinate replaces it
      resp_q  <= RESP_DECERR;
      rdata_q <= '0;
    end else if (dn_done) begin
      resp_q  <= dn_req.b_ready ? dn_rsp.b_resp : dn_rsp.r_resp;
      rdata_q <= dn_rsp.r_data;
    end
  end

  // a port counts as busy while it gets a request or still presents a response
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((natv_req_o.aw_valid || natv_req_o.w_valid || natv_req_o.ar_valid
       || natv_rsp_i.b_valid || natv_rsp_i.r_valid)
      && (apb_req_o.aw_valid || apb_req_o.w_valid || apb_req_o.ar_valid
          || apb_rsp_i.b_valid || apb_rsp_i.r_valid)))
    else $error("xbar has transactions open on both downstream ports");

endmodule

// ==== design/natv_gpio.sv ====
module natv_gpio #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::axil_req_t req_i,
  output soc_bus_pkg::axil_rsp_t rsp_o,
  input  logic [GPIO_WIDTH-1:0]  gpio_in_i,
  output logic [GPIO_WIDTH-1:0]  gpio_out_o,
  output logic [GPIO_WIDTH-1:0]  gpio_oen_o,
  output logic                   irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef logic [GPIO_WIDTH-1:0] pin_t;

  pin_t     out_q;
  pin_t     oen_q;
  pin_t     ie_q;
  pin_t     pend_q;
  pin_t     sync1_q;
  pin_t     sync2_q;
  pin_t     prev_q;
  pin_t     rise;
  pin_t     pmask;
  pin_t     pdata;
  logic     b_valid_q;
  logic     r_valid_q;
  resp_t    b_resp_q;
  resp_t    r_resp_q;
  data_t    rdata_q;
  data_t    rd_word;
  logic     rd_known;
  logic     wr_known;
  logic     wr_en;
  logic     rd_en;
  reg_off_t wr_off;
  reg_off_t rd_off;

  // aw and w are taken together, and only while no response is waiting
  assign wr_en = req_i.aw_valid && req_i.w_valid && !b_valid_q && !r_valid_q;
  assign rd_en = req_i.ar_valid && !req_i.aw_valid && !b_valid_q && !r_valid_q;

  assign rsp_o.aw_ready = wr_en;
  assign rsp_o.w_ready  = wr_en;
  assign rsp_o.ar_ready = rd_en;
  assign rsp_o.b_valid  = b_valid_q;
  assign rsp_o.b_resp   = b_resp_q;
  assign rsp_o.r_valid  = r_valid_q;
  assign rsp_o.r_data   = rdata_q;
  assign rsp_o.r_resp   = r_resp_q;

  assign wr_off   = reg_off_t'(req_i.aw_addr);
  assign rd_off   = reg_off_t'(req_i.ar_addr);
  assign wr_known = wr_off inside {GPIO_OUT, GPIO_OEN, GPIO_IN, GPIO_IE, GPIO_PEND};
  assign pmask    = pin_t'(strb_mask(req_i.w_strb));
  assign pdata    = pin_t'(req_i.w_data);

  // a pin counts as rising once it is past the synchronizer
  assign rise  = sync2_q & ~prev_q;
  assign irq_o = |(pend_q & ie_q);

  assign gpio_out_o = out_q;
  assign gpio_oen_o = oen_q;

  always_comb begin
    rd_known = 1'b1;
    case (rd_off)
      GPIO_OUT:  rd_word = data_t'(out_q);
      GPIO_OEN:  rd_word = data_t'(oen_q);
      GPIO_IN:   rd_word = data_t'(sync2_q);
      GPIO_IE:   rd_word = data_t'(ie_q);
      GPIO_PEND: rd_word = data_t'(pend_q);
      default: begin
        rd_word  = '0;
        rd_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oen_q     <= '0;
      ie_q      <= '0;
      pend_q    <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      pend_q  <= pend_q | rise;
      if (wr_en) begin
        case (wr_off)
          GPIO_OUT:  out_q <= (out_q & ~pmask) | (pdata & pmask);
          GPIO_OEN:  oen_q <= (oen_q & ~pmask) | (pdata & pmask);
          GPIO_IE:   ie_q <= (ie_q & ~pmask) | (pdata & pmask);
          // a new edge in the same cycle keeps its pending bit
          GPIO_PEND: pend_q <= (pend_q & ~(pdata & pmask)) | rise;
          default: ;
        endcase
      end
      if (wr_en) b_valid_q <= 1'b1;
      else if (req_i.b_ready) b_valid_q <= 1'b0;
      if (rd_en) r_valid_q <= 1'b1;
      else if (req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) b_resp_q <= wr_known ? RESP_OKAY : RESP_SLVERR;
    if (rd_en) begin
      rdata_q  <= rd_word;
      r_resp_q <= rd_known ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rsp_o.b_valid && rsp_o.r_valid))
    else $error("gpio answers a read and a write together");

endmodule

// ==== design/axil2apb_bridge.sv ====
module axil2apb_bridge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::axil_req_t req_i,
  output soc_bus_pkg::axil_rsp_t rsp_o,
  output soc_bus_pkg::apb_req_t  apb_req_o,
  input  soc_bus_pkg::apb_rsp_t  apb_rsp_i
);
  import soc_bus_pkg::*;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS,
    BR_RESP
  } br_state_e;

  br_state_e state_q;
  logic      is_wr_q;
  addr_t     paddr_q;
  data_t     pwdata_q;
  strb_t     pstrb_q;
  data_t     prdata_q;
  resp_t     resp_q;
  logic      wr_take;
  logic      rd_take;
  logic      apb_done;
  logic      axi_done;

  // a write needs both beats present before it is taken
  assign wr_take  = (state_q == BR_IDLE) && req_i.aw_valid && req_i.w_valid;
  assign rd_take  = (state_q == BR_IDLE) && req_i.ar_valid && !req_i.aw_valid;
  assign apb_done = (state_q == BR_ACCESS) && apb_rsp_i.pready;
  assign axi_done = (rsp_o.b_valid && req_i.b_ready) || (rsp_o.r_valid && req_i.r_ready);

  assign rsp_o.aw_ready = wr_take;
  assign rsp_o.w_ready  = wr_take;
  assign rsp_o.ar_ready = rd_take;
  assign rsp_o.b_valid  = (state_q == BR_RESP) && is_wr_q;
  assign rsp_o.b_resp   = resp_q;
  assign rsp_o.r_valid  = (state_q == BR_RESP) && !is_wr_q;
  assign rsp_o.r_data   = prdata_q;
  assign rsp_o.r_resp   = resp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.psel    = (state_q == BR_SETUP) || (state_q == BR_ACCESS);
  assign apb_req_o.penable = state_q == BR_ACCESS;
  assign apb_req_o.pwrite  = is_wr_q;
  assign apb_req_o.pwdata  = pwdata_q;
  assign apb_req_o.pstrb   = pstrb_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BR_IDLE;
      is_wr_q <= 1'b0;
    end else begin
      unique case (state_q)
        BR_IDLE: begin
          if (wr_take || rd_take) begin
            is_wr_q <= wr_take;
            state_q <= BR_SETUP;
          end
        end
        BR_SETUP:  state_q <= BR_ACCESS;
        // wait states stretch the access phase
        BR_ACCESS: if (apb_done) state_q <= BR_RESP;
        BR_RESP:   if (axi_done) state_q <= BR_IDLE;
        default:   state_q <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      paddr_q  <= req_i.aw_addr;
      pwdata_q <= req_i.w_data;
      pstrb_q  <= req_i.w_strb;
    end else if (rd_take) begin
      paddr_q  <= req_i.ar_addr;
      pwdata_q <= '0;
      // APB wants no strobes on a read
      pstrb_q  <= '0;
    end
    if (apb_done) begin
      prdata_q <= apb_rsp_i.prdata;
      resp_q   <= apb_rsp_i.pslverr ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // every access phase follows a setup phase with psel already high
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_o.penable |-> apb_req_o.psel && $past(apb_req_o.psel))
    else $error("penable without a preceding setup phase");

endmodule

// ==== design/apb_timer.sv ====
module apb_timer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::apb_req_t apb_req_i,
  output soc_bus_pkg::apb_rsp_t apb_rsp_o,
  output logic                  irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t    load_q;
  data_t    count_q;
  logic     en_q;
  logic     flag_q;
  reg_off_t off;
  logic     known;
  logic     wr_en;
  data_t    wmask;
  data_t    load_next;
  logic     wrap;
  logic     stat_clr;

  assign off       = reg_off_t'(apb_req_i.paddr);
  assign known     = off inside {TMR_LOAD, TMR_CTRL, TMR_COUNT, TMR_STAT};
  assign wr_en     = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && known;
  assign wmask     = strb_mask(apb_req_i.pstrb);
  assign load_next = (load_q & ~wmask) | (apb_req_i.pwdata & wmask);
  assign wrap      = en_q && (count_q == '0);
  assign stat_clr  = wr_en && (off == TMR_STAT) && apb_req_i.pstrb[0] && apb_req_i.pwdata[0];

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = apb_req_i.psel && !known;
  assign irq_o             = flag_q;

  always_comb begin
    case (off)
      TMR_LOAD:  apb_rsp_o.prdata = load_q;
      TMR_CTRL:  apb_rsp_o.prdata = {31'd0, en_q};
      TMR_COUNT: apb_rsp_o.prdata = count_q;
      TMR_STAT:  apb_rsp_o.prdata = {31'd0, flag_q};
      default:   apb_rsp_o.prdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      load_q  <= '0;
      count_q <= '0;
      en_q    <= 1'b0;
      flag_q  <= 1'b0;
    end else begin
      // writing LOAD also restarts the count from the new value
      if (wr_en && (off == TMR_LOAD)) begin
        load_q  <= load_next;
        count_q <= load_next;
      end else if (en_q) begin
        count_q <= wrap ? load_q : count_q - 1'b1;
      end
      if (wr_en && (off == TMR_CTRL) && apb_req_i.pstrb[0]) en_q <= apb_req_i.pwdata[0];
      // an expiry in the same cycle as the clear keeps the flag set
      flag_q <= (flag_q && !stat_clr) || wrap;
    end
  end

endmodule

// ==== design/soc_top.sv ====
module soc_top #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  soc_bus_pkg::axil_req_t           mgr_req_i,
  output soc_bus_pkg::axil_rsp_t           mgr_rsp_o,
  input  logic [GPIO_WIDTH-1:0]            gpio_in_i,
  output logic [GPIO_WIDTH-1:0]            gpio_out_o,
  output logic [GPIO_WIDTH-1:0]            gpio_oen_o,
  output logic [soc_map_pkg::IRQ_NUM-1:0] irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  axil_req_t natv_req;
  axil_rsp_t natv_rsp;
  axil_req_t apb_axil_req;
  axil_rsp_t apb_axil_rsp;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      gpio_irq;
  logic      tmr_irq;

  // peripheral interrupts gathered into one vector
  assign irq_o[IRQ_GPIO] = gpio_irq;
  assign irq_o[IRQ_TMR]  = tmr_irq;

  axil_xbar u_axil_xbar (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mgr_req_i (mgr_req_i),
    .mgr_rsp_o (mgr_rsp_o),
    .natv_req_o(natv_req),
    .natv_rsp_i(natv_rsp),
    .apb_req_o (apb_axil_req),
    .apb_rsp_i (apb_axil_rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // native region
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  natv_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_natv_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (natv_req),
    .rsp_o     (natv_rsp),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oen_o(gpio_oen_o),
    .irq_o     (gpio_irq)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB region
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  axil2apb_bridge u_axil2apb_bridge (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (apb_axil_req),
    .rsp_o    (apb_axil_rsp),
    .apb_req_o(apb_req),
    .apb_rsp_i(apb_rsp)
  );

  apb_timer u_apb_timer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .apb_req_i(apb_req),
    .apb_rsp_o(apb_rsp),
    .irq_o    (tmr_irq)
  );

endmodule

// ==== verification/soc_tb.sv ====
module soc_tb;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int    GPIO_WIDTH = 8;
  localparam data_t PIN_MASK   = data_t'((64'd1 << GPIO_WIDTH) - 1);
  localparam data_t TMR_RELOAD = 32'd20;

  typedef enum logic [1:0] {
    K_WRITE,
    K_READ,
    K_SET_IN,
    K_WAIT_IRQ
  } step_kind_e;

  // a wait step keeps its irq bit in data and its cycle budget in exp_data
  typedef struct packed {
    step_kind_e         kind;
    addr_t              addr;
    data_t              data;
    strb_t              strb;
    data_t              exp_data;
    resp_t              exp_resp;
    logic [IRQ_NUM-1:0] exp_irq;
  } step_t;

  logic                  clk;
  logic                  rst_n;
  axil_req_t             mgr_req;
  axil_rsp_t             mgr_rsp;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oen;
  logic [IRQ_NUM-1:0]    irq;
  step_t                 steps[$];
  string                 names[$];
  logic                  table_done;

  soc_top #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .mgr_req_i (mgr_req),
    .mgr_rsp_o (mgr_rsp),
    .gpio_in_i (gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_oen_o(gpio_oen),
    .irq_o     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic addr_t natv_addr(reg_off_t off);
    return NATV_BASE | addr_t'(off);
  endfunction

  function automatic addr_t apb_addr(reg_off_t off);
    return APB_BASE | addr_t'(off);
  endfunction

  // bytes with their strobe set take the new value
  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic void add_step(string name, step_kind_e kind, addr_t addr, data_t data,
                                   strb_t strb, data_t exp_data, resp_t exp_resp,
                                   logic [IRQ_NUM-1:0] exp_irq);
    step_t s;
    s.kind     = kind;
    s.addr     = addr;
    s.data     = data;
    s.strb     = strb;
    s.exp_data = exp_data;
    s.exp_resp = exp_resp;
    s.exp_irq  = exp_irq;
    steps.push_back(s);
    names.push_back(name);
  endfunction

  task automatic report_mismatch(input string name, input data_t exp, input data_t act);
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    $display("Done: errors found");
    $fatal(1, "mismatch in step %s", name);
  endtask

  task automatic abort_run(input string msg);
    $display("Done: errors found");
    $fatal(1, "%s", msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    mgr_req.aw_valid = 1'b1;
    mgr_req.aw_addr  = addr;
    mgr_req.w_valid  = 1'b1;
    mgr_req.w_data   = data;
    mgr_req.w_strb   = strb;
    mgr_req.b_ready  = 1'b1;
    // aw and w may be taken in different cycles
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (mgr_rsp.aw_ready) aw_done = 1'b1;
      if (mgr_rsp.w_ready) w_done = 1'b1;
      @(negedge clk);
      if (aw_done) mgr_req.aw_valid = 1'b0;
      if (w_done) mgr_req.w_valid = 1'b0;
    end
    do begin
      @(posedge clk);
    end while (!mgr_rsp.b_valid);
    resp = mgr_rsp.b_resp;
    @(negedge clk);
    mgr_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp);
    logic ar_done;
    ar_done = 1'b0;
    @(negedge clk);
    mgr_req.ar_valid = 1'b1;
    mgr_req.ar_addr  = addr;
    mgr_req.r_ready  = 1'b1;
    while (!ar_done) begin
      @(posedge clk);
      ar_done = mgr_rsp.ar_ready;
      @(negedge clk);
    end
    mgr_req.ar_valid = 1'b0;
    do begin
      @(posedge clk);
    end while (!mgr_rsp.r_valid);
    data = mgr_rsp.r_data;
    resp = mgr_rsp.r_resp;
    @(negedge clk);
    mgr_req.r_ready = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_table();
    data_t out_m;
    data_t oen_m;
    data_t pins;
    data_t rnd;
    out_m = '0;
    oen_m = '0;
    add_step("rst_gpio_out", K_READ, natv_addr(GPIO_OUT), '0, '0, '0, RESP_OKAY, 2'b00);
    add_step("rst_gpio_oen", K_READ, natv_addr(GPIO_OEN), '0, '0, '0, RESP_OKAY, 2'b00);
    add_step("rst_tmr_ctrl", K_READ, apb_addr(TMR_CTRL), '0, '0, '0, RESP_OKAY, 2'b00);
    add_step("rst_tmr_stat", K_READ, apb_addr(TMR_STAT), '0, '0, '0, RESP_OKAY, 2'b00);

    // only byte 0 reaches the pins, so a strobe without bit 0 leaves them alone
    rnd   = $urandom;
    out_m = merge_bytes(out_m, rnd, 4'hF) & PIN_MASK;
    add_step("out_full", K_WRITE, natv_addr(GPIO_OUT), rnd, 4'hF, '0, RESP_OKAY, 2'b00);
    rnd   = $urandom;
    out_m = merge_bytes(out_m, rnd, 4'b1110) & PIN_MASK;
    add_step("out_partial", K_WRITE, natv_addr(GPIO_OUT), rnd, 4'b1110, '0, RESP_OKAY, 2'b00);
    rnd   = $urandom;
    oen_m = merge_bytes(oen_m, rnd, 4'hF) & PIN_MASK;
    add_step("oen_full", K_WRITE, natv_addr(GPIO_OEN), rnd, 4'hF, '0, RESP_OKAY, 2'b00);
    rnd   = $urandom;
    oen_m = merge_bytes(oen_m, rnd, 4'b0011) & PIN_MASK;
    add_step("oen_partial", K_WRITE, natv_addr(GPIO_OEN), rnd, 4'b0011, '0, RESP_OKAY, 2'b00);
    add_step("out_readback", K_READ, natv_addr(GPIO_OUT), '0, '0, out_m, RESP_OKAY, 2'b00);
    add_step("oen_readback", K_READ, natv_addr(GPIO_OEN), '0, '0, oen_m, RESP_OKAY, 2'b00);

    // bit 0 always rises so the enabled interrupt fires
    pins = ($urandom & PIN_MASK) | 32'd1;
    add_step("ie_enable", K_WRITE, natv_addr(GPIO_IE), 32'd1, 4'hF, '0, RESP_OKAY, 2'b00);
    add_step("in_drive", K_SET_IN, '0, pins, '0, '0, RESP_OKAY, 2'b00);
    add_step("in_irq", K_WAIT_IRQ, '0, IRQ_GPIO, '0, 32'd10, RESP_OKAY, 2'b01);
    add_step("in_readback", K_READ, natv_addr(GPIO_IN), '0, '0, pins, RESP_OKAY, 2'b01);
    add_step("pend_read", K_READ, natv_addr(GPIO_PEND), '0, '0, pins, RESP_OKAY, 2'b01);
    add_step("pend_clear", K_WRITE, natv_addr(GPIO_PEND), 32'd1, 4'hF, '0, RESP_OKAY, 2'b00);
    add_step("pend_after", K_READ, natv_addr(GPIO_PEND), '0, '0, pins & ~32'd1, RESP_OKAY,
             2'b00);

    add_step("tmr_load", K_WRITE, apb_addr(TMR_LOAD), TMR_RELOAD, 4'hF, '0, RESP_OKAY, 2'b00);
    add_step("tmr_enable", K_WRITE, apb_addr(TMR_CTRL), 32'd1, 4'hF, '0, RESP_OKAY, 2'b00);
    add_step("tmr_irq", K_WAIT_IRQ, '0, IRQ_TMR, '0, TMR_RELOAD + 2, RESP_OKAY, 2'b10);
    add_step("tmr_stat_set", K_READ, apb_addr(TMR_STAT), '0, '0, 32'd1, RESP_OKAY, 2'b10);
    add_step("tmr_disable", K_WRITE, apb_addr(TMR_CTRL), '0, 4'hF, '0, RESP_OKAY, 2'b10);
    add_step("tmr_stat_clear", K_WRITE, apb_addr(TMR_STAT), 32'd1, 4'hF, '0, RESP_OKAY, 2'b00);
    add_step("tmr_stat_after", K_READ, apb_addr(TMR_STAT), '0, '0, '0, RESP_OKAY, 2'b00);
    add_step("tmr_load_back", K_READ, apb_addr(TMR_LOAD), '0, '0, TMR_RELOAD, RESP_OKAY, 2'b00);

    add_step("unmapped_rd", K_READ, 32'h3000_0000, '0, '0, '0, RESP_DECERR, 2'b00);
    add_step("unmapped_wr", K_WRITE, 32'h1000_1000, ~out_m, 4'hF, '0, RESP_DECERR, 2'b00);
    add_step("tmr_bad_rd", K_READ, apb_addr(12'h010), '0, '0, '0, RESP_SLVERR, 2'b00);
    add_step("tmr_bad_wr", K_WRITE, apb_addr(12'h010), 32'hFFFF_FFFF, 4'hF, '0, RESP_SLVERR,
             2'b00);
    add_step("out_unchanged", K_READ, natv_addr(GPIO_OUT), '0, '0, out_m, RESP_OKAY, 2'b00);
  endtask

  task automatic run_step(input int i);
    step_t s;
    data_t rdata;
    resp_t resp;
    int    waited;
    s = steps[i];
    case (s.kind)
      K_WRITE: begin
        axil_write(s.addr, s.data, s.strb, resp);
        assert (resp == s.exp_resp)
          else report_mismatch(names[i], data_t'(s.exp_resp), data_t'(resp));
      end
      K_READ: begin
        axil_read(s.addr, rdata, resp);
        assert (resp == s.exp_resp)
          else report_mismatch(names[i], data_t'(s.exp_resp), data_t'(resp));
        // read data that comes with SLVERR carries no meaning
        if (s.exp_resp != RESP_SLVERR) begin
          assert (rdata == s.exp_data) else report_mismatch(names[i], s.exp_data, rdata);
        end
        if (s.addr == natv_addr(GPIO_OUT)) begin
          assert (data_t'(gpio_out) == s.exp_data)
            else report_mismatch({names[i], " pins"}, s.exp_data, data_t'(gpio_out));
        end
        if (s.addr == natv_addr(GPIO_OEN)) begin
          assert (data_t'(gpio_oen) == s.exp_data)
            else report_mismatch({names[i], " pins"}, s.exp_data, data_t'(gpio_oen));
        end
      end
      K_SET_IN: begin
        @(negedge clk);
        gpio_in = s.data[GPIO_WIDTH-1:0];
      end
      K_WAIT_IRQ: begin
        waited = 0;
        while (!irq[int'(s.data)] && waited < int'(s.exp_data)) begin
          @(negedge clk);
          waited++;
        end
        assert (irq[int'(s.data)])
          else abort_run($sformatf("irq bit %0d did not rise within %0d cycles in step %s",
                                   s.data, s.exp_data, names[i]));
      end
      default: abort_run($sformatf("step %s has no known kind", names[i]));
    endcase
    if (s.kind != K_SET_IN) begin
      assert (irq == s.exp_irq)
        else report_mismatch({names[i], " irq"}, data_t'(s.exp_irq), data_t'(irq));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    void'($urandom(11534));
    mgr_req    = '0;
    gpio_in    = '0;
    rst_n      = 1'b0;
    table_done = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (steps[i]) begin
      run_step(i);
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin
    int    limit;
    data_t max_load;
    wait (table_done);
    max_load = '0;
    foreach (steps[i]) begin
      if (steps[i].kind == K_WRITE && steps[i].addr == apb_addr(TMR_LOAD)
          && steps[i].data > max_load) begin
        max_load = steps[i].data;
      end
    end
    limit = 40 * steps.size() + int'(max_load);
    repeat (limit) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles, the run is stuck", limit));
  end

endmodule

// ==== list.f ====
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/axil_xbar.sv
design/natv_gpio.sv
design/axil2apb_bridge.sv
design/apb_timer.sv
design/soc_top.sv
verification/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f list.f &&
  ./obj_dir/Vsoc_tb ||
  { echo "simulation failed" >&2; exit 1; }
